//--- test/mem_golden.txt
// op f3 addr wdata expect hit (op 0 load, 1 store, 2 fence, 3 memory word check, 4 end)
// end line holds the expected hit count in wdata and the miss count in expect
0 0 100 0 ffffffffffffffb4 0
0 4 101 0 c3 1
0 0 102 0 ffffffffffffff96 1
0 4 103 0 7e 1
0 0 104 0 5 1
0 4 105 0 f0 1
0 0 106 0 3c 1
0 0 107 0 ffffffffffffff8a 1
0 1 100 0 ffffffffffffc3b4 1
0 5 102 0 7e96 1
0 1 104 0 fffffffffffff005 1
0 5 106 0 8a3c 1
0 2 100 0 7e96c3b4 1
0 6 104 0 8a3cf005 1
0 2 104 0 ffffffff8a3cf005 1
0 3 100 0 8a3cf0057e96c3b4 1
1 0 109 a5 0 1
1 1 10c 1234 0 1
0 3 108 0 8a3c12347e96a5bc 1
1 2 110 deadbeef 0 1
1 3 118 0123456789abcdef 0 1
0 2 110 0 ffffffffdeadbeef 1
0 1 10c 0 1234 1
0 3 300 0 8a3cf2057e96c1b4 0
0 3 118 0 0123456789abcdef 0
1 0 500 7f 0 0
1 3 48 cafef00d12345678 0 0
2 0 0 0 0 0
3 0 500 0 8a3cf4057e96c77f 0
3 0 48 0 cafef00d12345678 0
3 0 110 0 8a3cf015deadbeef 0
3 0 108 0 8a3c12347e96a5bc 0
0 4 500 0 7f 0
0 2 4c 0 ffffffffcafef00d 0
4 0 0 16 7 0

//--- tb.f
common/mem_pkg.sv
common/dcache_req_if.sv
logic/mem_stage.sv
dcache/dcache.sv
dcache/dcache_perf_counters.sv
logic/mem_subsys.sv
test/tb_clock_gen.sv
test/tb_burst_mem.sv
test/tb_mem_subsys.sv

//--- test/tb_mem_subsys.sv
module tb_mem_subsys import mem_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int GOLDEN_COLS  = 6;
    localparam int GOLDEN_RECS  = 35;
    localparam int ACCESS_BOUND = 400; // cycles, enough for a fence flushing every line

    logic              clk;
    logic              rst_i;
    logic              mem_valid_i;
    logic              wen_i;
    logic              fence_i;
    mem_op_e           func3_i;
    logic [ADDR_W-1:0] addr_i;
    logic [XLEN-1:0]   wdata_i;
    logic              mem_ready_o;
    logic [XLEN-1:0]   r_data_o;
    logic              r_valid_o;
    logic [ADDR_W-1:0] r_addr_o;
    logic              r_ready_i;
    logic              r_last_i;
    logic [XLEN-1:0]   r_data_i;
    logic              w_valid_o;
    logic [ADDR_W-1:0] w_addr_o;
    logic [XLEN-1:0]   w_data_o;
    logic              w_ready_i;
    logic              w_last_i;
    logic [63:0]       cache_hit_o;
    logic [63:0]       cache_miss_o;

    logic [XLEN-1:0] golden [GOLDEN_RECS * GOLDEN_COLS];
    int              data_errs  = 0;
    int              count_errs = 0;
    int              other_errs = 0;
    logic            ready_prev = 1'b0;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) clock_gen_i (
        .clk_o (clk),
        .rst_o (rst_i)
    );

    mem_subsys #(
        .LINE_COUNT (16)
    ) mem_subsys_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .mem_valid_i  (mem_valid_i),
        .wen_i        (wen_i),
        .fence_i      (fence_i),
        .func3_i      (func3_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .mem_ready_o  (mem_ready_o),
        .r_data_o     (r_data_o),
        .r_valid_o    (r_valid_o),
        .r_addr_o     (r_addr_o),
        .r_ready_i    (r_ready_i),
        .r_last_i     (r_last_i),
        .r_data_i     (r_data_i),
        .w_valid_o    (w_valid_o),
        .w_addr_o     (w_addr_o),
        .w_data_o     (w_data_o),
        .w_ready_i    (w_ready_i),
        .w_last_i     (w_last_i),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o)
    );

    tb_burst_mem burst_mem_i (
        .clk_i     (clk),
        .r_valid_i (r_valid_o),
        .r_addr_i  (r_addr_o),
        .r_ready_o (r_ready_i),
        .r_last_o  (r_last_i),
        .r_data_o  (r_data_i),
        .w_valid_i (w_valid_o),
        .w_addr_i  (w_addr_o),
        .w_data_i  (w_data_o),
        .w_ready_o (w_ready_i),
        .w_last_o  (w_last_i)
    );

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_count(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            count_errs++;
        end
    endtask

    task automatic report_counts();
        $display("errors: data %0d, counters %0d, other %0d", data_errs, count_errs,
                 other_errs);
    endtask

    // one load or store, started and ended on falling edges
    task automatic run_access(input logic store, input mem_op_e op,
                              input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] wdata,
                              input logic [XLEN-1:0] exp, input logic exp_hit);
        int cycles;
        mem_valid_i = 1'b1;
        wen_i       = store;
        func3_i     = op;
        addr_i      = addr;
        wdata_i     = wdata;
        cycles      = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (mem_ready_o !== 1'b1);
        check_data("r_data_o", r_data_o, exp);
        if (exp_hit && cycles != 2) begin
            $display("hit at address %h answered after %0d cycles instead of 2", addr, cycles);
            other_errs++;
        end
        mem_valid_i = 1'b0;
        wen_i       = 1'b0;
        @(negedge clk); // idle cycle between requests
    endtask

    task automatic run_fence();
        fence_i = 1'b1;
        do begin
            @(negedge clk);
        end while (mem_ready_o !== 1'b1);
        check_data("r_data_o", r_data_o, '0);
        fence_i = 1'b0;
        @(negedge clk);
    endtask

    // a pulse must never last two cycles
    always @(negedge clk) begin
        if (mem_ready_o === 1'b1 && ready_prev) begin
            $display("mem_ready_o stayed high for two cycles at %0t", $time);
            other_errs++;
        end
        ready_prev = mem_ready_o;
    end

    initial begin
        int base;
        mem_valid_i = 1'b0;
        wen_i       = 1'b0;
        fence_i     = 1'b0;
        func3_i     = OP_B;
        addr_i      = '0;
        wdata_i     = '0;
        $readmemh("test/mem_golden.txt", golden);
        wait (rst_i === 1'b0);
        @(negedge clk);
        for (int r = 0; r < GOLDEN_RECS; r++) begin
            base = r * GOLDEN_COLS;
            case (golden[base])
                0, 1: run_access(golden[base][0], mem_op_e'(golden[base + 1][2:0]),
                                 golden[base + 2][ADDR_W-1:0], golden[base + 3],
                                 golden[base + 4], golden[base + 5][0]);
                2: run_fence();
                3: check_data($sformatf("memory word %0h", golden[base + 2]),
                              burst_mem_i.mem[golden[base + 2][12:3]], golden[base + 4]);
                4: begin
                    check_count("cache_hit_o", cache_hit_o, golden[base + 3]);
                    check_count("cache_miss_o", cache_miss_o, golden[base + 4]);
                end
                default: begin
                    $display("golden record %0d has an unknown op %0h", r, golden[base]);
                    other_errs++;
                end
            endcase
        end
        report_counts();
        if (data_errs + count_errs + other_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (GOLDEN_RECS * ACCESS_BOUND + 10));
        $display("timeout, the golden run did not finish within %0d cycles",
                 GOLDEN_RECS * ACCESS_BOUND + 10);
        report_counts();
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- test/tb_burst_mem.sv
module tb_burst_mem import mem_pkg::*; (
    input  logic              clk_i,
    input  logic              r_valid_i,
    input  logic [ADDR_W-1:0] r_addr_i,
    output logic              r_ready_o,
    output logic              r_last_o,
    output logic [XLEN-1:0]   r_data_o,
    input  logic              w_valid_i,
    input  logic [ADDR_W-1:0] w_addr_i,
    input  logic [XLEN-1:0]   w_data_i,
    output logic              w_ready_o,
    output logic              w_last_o
);

    localparam int WORDS = 1024; // 8 KiB of 64-bit words
    // preset word at byte address a is (a * 64'h0000_0001_0000_0001) ^ PRESET_XOR
    localparam logic [XLEN-1:0] PRESET_XOR = 64'h8a3c_f105_7e96_c2b4;

    logic [XLEN-1:0] mem [WORDS];
    logic [31:0]     lfsr;
    int              rbeat;
    int              wbeat;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic int word_index(input logic [ADDR_W-1:0] base, input int beat);
        return int'(base[12:3]) + beat;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (64'(i * 8) * 64'h0000_0001_0000_0001) ^ PRESET_XOR;
        end
        lfsr      = 32'h31e279ab;
        rbeat     = 0;
        wbeat     = 0;
        r_ready_o = 1'b0;
        r_last_o  = 1'b0;
        r_data_o  = '0;
        w_ready_o = 1'b0;
        w_last_o  = 1'b0;
    end

    always @(negedge clk_i) begin
        // a beat offered with ready high was taken at the last rising edge
        if (r_ready_o) begin
            rbeat = r_last_o ? 0 : rbeat + 1;
        end
        if (w_ready_o) begin
            wbeat = w_last_o ? 0 : wbeat + 1;
        end
        r_ready_o = 1'b0;
        r_last_o  = 1'b0;
        w_ready_o = 1'b0;
        w_last_o  = 1'b0;
        if (r_valid_i) begin
            lfsr      = lfsr_step(lfsr);
            r_ready_o = lfsr[0]; // random stall
            r_data_o  = mem[word_index(r_addr_i, rbeat)];
            r_last_o  = lfsr[0] && (rbeat == LINE_WORDS - 1);
        end
        if (w_valid_i) begin
            lfsr      = lfsr_step(lfsr);
            w_ready_o = lfsr[0];
            w_last_o  = lfsr[0] && (wbeat == LINE_WORDS - 1);
            if (w_ready_o) begin
                mem[word_index(w_addr_i, wbeat)] = w_data_i; // accepted at next edge
            end
        end
    end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0; // released between edges
    end

endmodule

//--- logic/mem_subsys.sv
module mem_subsys import mem_pkg::*; #(
    parameter int LINE_COUNT = 16
) (
    input  logic              clk,
    input  logic              rst_i,
    // pipeline side
    input  logic              mem_valid_i,
    input  logic              wen_i,
    input  logic              fence_i,
    input  mem_op_e           func3_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic              mem_ready_o,
    output logic [XLEN-1:0]   r_data_o,
    // burst port
    output logic              r_valid_o,
    output logic [ADDR_W-1:0] r_addr_o,
    input  logic              r_ready_i,
    input  logic              r_last_i,
    input  logic [XLEN-1:0]   r_data_i,
    output logic              w_valid_o,
    output logic [ADDR_W-1:0] w_addr_o,
    output logic [XLEN-1:0]   w_data_o,
    input  logic              w_ready_i,
    input  logic              w_last_i,
    // performance counters
    output logic [63:0]       cache_hit_o,
    output logic [63:0]       cache_miss_o
);

    logic hit;
    logic miss;

    dcache_req_if req_if ();

    mem_stage mem_stage_i (
        .clk         (clk),
        .mem_valid_i (mem_valid_i),
        .wen_i       (wen_i),
        .fence_i     (fence_i),
        .func3_i     (func3_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .mem_ready_o (mem_ready_o),
        .r_data_o    (r_data_o),
        .req         (req_if)
    );

    dcache #(
        .LINE_COUNT (LINE_COUNT)
    ) dcache_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .req       (req_if),
        .hit_o     (hit),
        .miss_o    (miss),
        .r_valid_o (r_valid_o),
        .r_addr_o  (r_addr_o),
        .r_ready_i (r_ready_i),
        .r_last_i  (r_last_i),
        .r_data_i  (r_data_i),
        .w_valid_o (w_valid_o),
        .w_addr_o  (w_addr_o),
        .w_data_o  (w_data_o),
        .w_ready_i (w_ready_i),
        .w_last_i  (w_last_i)
    );

    dcache_perf_counters perf_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .hit_i        (hit),
        .miss_i       (miss),
        .cache_hit_o  (cache_hit_o),
        .cache_miss_o (cache_miss_o)
    );

endmodule

//--- dcache/dcache_perf_counters.sv
module dcache_perf_counters (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        hit_i,
    input  logic        miss_i,
    output logic [63:0] cache_hit_o,
    output logic [63:0] cache_miss_o
);

    // one pulse per lookup, so at most one counter moves per cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cache_hit_o <= '0;
        end else if (hit_i) begin
            cache_hit_o <= cache_hit_o + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cache_miss_o <= '0;
        end else if (miss_i) begin
            cache_miss_o <= cache_miss_o + 64'd1;
        end
    end

endmodule

//--- dcache/dcache.sv
module dcache import mem_pkg::*; #(
    parameter int LINE_COUNT = 16
) (
    input  logic              clk,
    input  logic              rst_i,
    dcache_req_if.cache       req,
    output logic              hit_o,
    output logic              miss_o,
    output logic              r_valid_o,
    output logic [ADDR_W-1:0] r_addr_o,
    input  logic              r_ready_i,
    input  logic              r_last_i,
    input  logic [XLEN-1:0]   r_data_i,
    output logic              w_valid_o,
    output logic [ADDR_W-1:0] w_addr_o,
    output logic [XLEN-1:0]   w_data_o,
    input  logic              w_ready_i,
    input  logic              w_last_i
);

    localparam int INDEX_W = $clog2(LINE_COUNT);
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

    dcache_state_e         state_q;
    logic [TAG_W-1:0]      tag_q [LINE_COUNT];
    logic [XLEN-1:0]       data_q [LINE_COUNT][LINE_WORDS];
    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;
    logic [INDEX_W-1:0]    line_q; // request index, or scan index during a fence
    logic [WORD_SEL_W-1:0] beat_q;
    logic [ADDR_W-1:0]     addr_q;
    logic                  wen_q;
    logic [XLEN-1:0]       wdata_q;
    logic [XLEN/8-1:0]     wmask_q;
    logic                  retry_q; // lookup after a refill, no event
    logic                  ready_q;
    logic [XLEN-1:0]       rdata_q;

    logic [TAG_W-1:0]      req_tag;
    logic [WORD_SEL_W-1:0] req_word;
    logic                  hit;
    logic                  store_hit;
    logic                  refill_beat;

    assign req_tag     = addr_q[ADDR_W-1 -: TAG_W];
    assign req_word    = addr_q[BYTE_SEL_W +: WORD_SEL_W];
    assign hit         = valid_q[line_q] && (tag_q[line_q] == req_tag);
    assign store_hit   = (state_q == LOOKUP) && hit && wen_q;
    assign refill_beat = (state_q == REFILL) && r_ready_i;

    assign hit_o  = (state_q == LOOKUP) && hit && !retry_q;
    assign miss_o = (state_q == LOOKUP) && !hit;

    assign r_valid_o = (state_q == REFILL);
    assign r_addr_o  = {req_tag, line_q, {OFFSET_W{1'b0}}};
    assign w_valid_o = (state_q == WBACK) || (state_q == FLUSH_WB);
    assign w_addr_o  = {tag_q[line_q], line_q, {OFFSET_W{1'b0}}};
    assign w_data_o  = data_q[line_q][beat_q];

    assign req.ready = ready_q;
    assign req.rdata = rdata_q;

    // storage and request payload
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req.valid) begin
            addr_q  <= req.addr;
            wen_q   <= req.wen;
            wdata_q <= req.wdata;
            wmask_q <= req.wmask;
        end
        if (refill_beat) begin
            data_q[line_q][beat_q] <= r_data_i;
            if (r_last_i) begin
                tag_q[line_q] <= req_tag;
            end
        end
        if (store_hit) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (wmask_q[b]) begin
                    data_q[line_q][req_word][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
        if (state_q == LOOKUP && hit) begin
            rdata_q <= data_q[line_q][req_word]; // old word, ignored for stores
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            line_q  <= '0;
            beat_q  <= '0;
            retry_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    retry_q <= 1'b0;
                    beat_q  <= '0;
                    if (req.fence) begin
                        line_q  <= '0;
                        state_q <= FLUSH_SCAN;
                    end else if (req.valid) begin
                        line_q  <= req.addr[OFFSET_W +: INDEX_W];
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        ready_q <= 1'b1;
                        if (wen_q) begin
                            dirty_q[line_q] <= 1'b1;
                        end
                        state_q <= IDLE;
                    end else if (valid_q[line_q] && dirty_q[line_q]) begin
                        state_q <= WBACK; // victim goes out first
                    end else begin
                        state_q <= REFILL;
                    end
                end
                WBACK, FLUSH_WB: begin
                    if (w_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (w_last_i) begin
                            beat_q          <= '0;
                            dirty_q[line_q] <= 1'b0;
                            state_q         <= (state_q == WBACK) ? REFILL : FLUSH_SCAN;
                        end
                    end
                end
                REFILL: begin
                    if (r_ready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (r_last_i) begin
                            beat_q          <= '0;
                            valid_q[line_q] <= 1'b1;
                            dirty_q[line_q] <= 1'b0;
                            retry_q         <= 1'b1;
                            state_q         <= LOOKUP; // now a guaranteed hit
                        end
                    end
                end
                FLUSH_SCAN: begin
                    if (valid_q[line_q] && dirty_q[line_q]) begin
                        state_q <= FLUSH_WB;
                    end else if (line_q == INDEX_W'(LINE_COUNT - 1)) begin
                        valid_q <= '0; // whole cache invalid once flushed
                        ready_q <= 1'b1;
                        state_q <= IDLE;
                    end else begin
                        line_q <= line_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

//--- logic/mem_stage.sv
module mem_stage import mem_pkg::*; (
    input  logic              clk,
    input  logic              mem_valid_i,
    input  logic              wen_i,
    input  logic              fence_i,
    input  mem_op_e           func3_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [XLEN-1:0]   wdata_i,
    output logic              mem_ready_o,
    output logic [XLEN-1:0]   r_data_o,
    dcache_req_if.stage       req
);

    logic [XLEN/8-1:0]     mask_base;
    logic [BYTE_SEL_W-1:0] offs_q;
    mem_op_e               op_q;
    logic                  load_q;
    logic [XLEN-1:0]       shifted;
    logic [XLEN-1:0]       ext;

    // store side: lane placement and byte enables
    always_comb begin
        case (func3_i)
            OP_B, OP_BU: mask_base = 8'h01;
            OP_H, OP_HU: mask_base = 8'h03;
            OP_W, OP_WU: mask_base = 8'h0f;
            default:     mask_base = '1; // sd
        endcase
    end

    assign req.valid = mem_valid_i;
    assign req.addr  = addr_i;
    assign req.wen   = wen_i;
    assign req.fence = fence_i;
    assign req.wdata = wdata_i << {addr_i[BYTE_SEL_W-1:0], 3'b000};
    assign req.wmask = mask_base << addr_i[BYTE_SEL_W-1:0];

    // format of the access in flight, used when the word comes back
    always_ff @(posedge clk) begin
        if (mem_valid_i || fence_i) begin
            offs_q <= addr_i[BYTE_SEL_W-1:0];
            op_q   <= func3_i;
            load_q <= mem_valid_i && !wen_i;
        end
    end

    always_comb begin
        shifted = req.rdata >> {offs_q, 3'b000};
        case (op_q)
            OP_B:    ext = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            OP_H:    ext = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            OP_W:    ext = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
            OP_BU:   ext = {{(XLEN-8){1'b0}}, shifted[7:0]};
            OP_HU:   ext = {{(XLEN-16){1'b0}}, shifted[15:0]};
            OP_WU:   ext = {{(XLEN-32){1'b0}}, shifted[31:0]};
            default: ext = shifted; // ld
        endcase
    end

    assign r_data_o    = load_q ? ext : '0;
    assign mem_ready_o = req.ready; // loads, stores and fences share one pulse

endmodule

//--- common/dcache_req_if.sv
interface dcache_req_if import mem_pkg::*; ();

    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic              wen;
    logic [XLEN-1:0]   wdata; // already placed in its byte lanes
    logic [XLEN/8-1:0] wmask;
    logic              fence;
    logic              ready; // one-cycle pulse per request
    logic [XLEN-1:0]   rdata; // whole word, valid with ready

    modport stage (
        output valid, addr, wen, wdata, wmask, fence,
        input  ready, rdata
    );

    modport cache (
        input  valid, addr, wen, wdata, wmask, fence,
        output ready, rdata
    );

endinterface

//--- common/mem_pkg.sv
package mem_pkg;

    localparam int XLEN       = 64;
    localparam int ADDR_W     = 32;
    localparam int LINE_WORDS = 4; // also beats per burst

    localparam int LINE_BYTES = LINE_WORDS * XLEN / 8;
    localparam int OFFSET_W   = $clog2(LINE_BYTES);  // byte offset inside a line
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);  // word index inside a line
    localparam int BYTE_SEL_W = OFFSET_W - WORD_SEL_W; // byte lane inside a word

    // funct3 encodings of the load/store group
    typedef enum logic [2:0] {
        OP_B  = 3'b000,
        OP_H  = 3'b001,
        OP_W  = 3'b010,
        OP_D  = 3'b011,
        OP_BU = 3'b100,
        OP_HU = 3'b101,
        OP_WU = 3'b110
    } mem_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WBACK,
        REFILL,
        FLUSH_SCAN,
        FLUSH_WB
    } dcache_state_e;

endpackage
